// ==== verilog/arith_pkg.sv ====
/*
  Arithmetic unit shared definitions
  Operand and product widths, the opcode and the payload
  carried between the operand, compute and result stages.
*/

`default_nettype none

package arith_pkg;

  localparam int DATA_WIDTH = 32;
  localparam int FRAC_WIDTH = 16;
  localparam int PROD_WIDTH = 2 * DATA_WIDTH;
  localparam int CNT_WIDTH  = $clog2(DATA_WIDTH) + 1;

  typedef enum logic {
    OP_MUL = 1'b0,
    OP_DIV = 1'b1
  } op_t;

  // Request after sign split
  typedef struct packed {
    op_t                   op;
    logic [DATA_WIDTH-1:0] left_mag;
    logic [DATA_WIDTH-1:0] right_mag;
    logic                  left_neg;
    logic                  right_neg;
  } req_t;

  // Unsigned result of the compute stage
  // For OP_DIV the remainder sits in the upper half, the quotient in the lower
  typedef struct packed {
    op_t                   op;
    logic                  left_neg;
    logic                  right_neg;
    logic [DATA_WIDTH-1:0] right_mag;
    logic [PROD_WIDTH-1:0] wide;
  } raw_t;

  // Final signed result
  typedef struct packed {
    logic [DATA_WIDTH-1:0] result;
    logic [DATA_WIDTH-1:0] remainder;
  } res_t;

endpackage

`default_nettype wire

// ==== verilog/stage_reg.sv ====
/*
  One-entry pipeline register with valid/ready handshake.
  Accepts a new entry in the same cycle the held one is taken.
*/

`timescale 1ns/1ps
`default_nettype none

module stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     in_ready,
  output logic     out_valid,
  output payload_t out_data,
  input  logic     out_ready
);

  // Free when empty or when the held entry leaves this cycle
  assign in_ready = !out_valid || out_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (in_valid && in_ready) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      out_data <= in_data;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/operand_stage.sv ====
/*
  Operand stage
  Splits both signed operands into magnitude and sign flag
  and registers them together with the opcode.
*/

`timescale 1ns/1ps
`default_nettype none

module operand_stage
  import arith_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  in_valid,
  input  op_t                   in_op,
  input  logic [DATA_WIDTH-1:0] in_left,
  input  logic [DATA_WIDTH-1:0] in_right,
  output logic                  in_ready,
  output logic                  req_valid,
  output req_t                  req_data,
  input  logic                  req_ready
);

  req_t req_next;

  // The most negative value keeps its pattern, read as unsigned it is correct
  always_comb begin
    req_next.op        = in_op;
    req_next.left_neg  = in_left[DATA_WIDTH-1];
    req_next.right_neg = in_right[DATA_WIDTH-1];
    req_next.left_mag  = in_left[DATA_WIDTH-1] ? -in_left : in_left;
    req_next.right_mag = in_right[DATA_WIDTH-1] ? -in_right : in_right;
  end

  stage_reg #(
    .payload_t(req_t)
  ) req_reg (
    .clk      (clk),
    .reset    (reset),
    .in_valid (in_valid),
    .in_data  (req_next),
    .in_ready (in_ready),
    .out_valid(req_valid),
    .out_data (req_data),
    .out_ready(req_ready)
  );

endmodule

`default_nettype wire

// ==== verilog/mult_unit.sv ====
/*
  Unsigned magnitude multiplier
  Two register stages: operands, then the full product.
  done pulses two cycles after start.
*/

`timescale 1ns/1ps
`default_nettype none

module mult_unit
  import arith_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  start,
  input  logic [DATA_WIDTH-1:0] left_mag,
  input  logic [DATA_WIDTH-1:0] right_mag,
  output logic                  done,
  output logic [PROD_WIDTH-1:0] product
);

  logic [DATA_WIDTH-1:0] left_q;
  logic [DATA_WIDTH-1:0] right_q;
  logic                  stage1_valid;

  // Valid bit walks alongside the data
  always_ff @(posedge clk) begin
    if (reset) begin
      stage1_valid <= 1'b0;
      done         <= 1'b0;
    end else begin
      stage1_valid <= start;
      done         <= stage1_valid;
    end
  end

  // Operand capture
  always_ff @(posedge clk) begin
    if (start) begin
      left_q  <= left_mag;
      right_q <= right_mag;
    end
  end

  // Product holds until the next operation reaches this stage
  always_ff @(posedge clk) begin
    if (stage1_valid) begin
      product <= left_q * right_q;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/div_unit.sv ====
/*
  Restoring divider for unsigned magnitudes
  One quotient bit per cycle, done DATA_WIDTH+1 cycles after start.
  A zero divisor finishes after one cycle with zero outputs.
*/

`timescale 1ns/1ps
`default_nettype none

module div_unit
  import arith_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  start,
  input  logic [DATA_WIDTH-1:0] dividend,
  input  logic [DATA_WIDTH-1:0] divisor,
  output logic                  done,
  output logic [DATA_WIDTH-1:0] quotient,
  output logic [DATA_WIDTH-1:0] remainder
);

  logic                  running;
  logic [CNT_WIDTH-1:0]  count;
  logic                  last;
  logic                  div_zero;
  logic [DATA_WIDTH-1:0] divisor_q;
  logic [DATA_WIDTH-1:0] rem_acc;
  logic [DATA_WIDTH-1:0] quo_acc;
  logic [DATA_WIDTH:0]   shifted;

  assign div_zero = (divisor == '0);
  assign last     = running && (count == CNT_WIDTH'(DATA_WIDTH));

  // Partial remainder with the next dividend bit shifted in
  assign shifted = {rem_acc, quo_acc[DATA_WIDTH-1]};

  always_ff @(posedge clk) begin
    if (reset) begin
      running <= 1'b0;
      done    <= 1'b0;
      count   <= '0;
    end else begin
      done <= 1'b0;
      if (start) begin
        count <= '0;
        if (div_zero) begin
          done <= 1'b1;
        end else begin
          running <= 1'b1;
        end
      end else if (last) begin
        running <= 1'b0;
        done    <= 1'b1;
      end else if (running) begin
        count <= count + 1'b1;
      end
    end
  end

  // Dividend bits leave the top of quo_acc as quotient bits enter the bottom
  always_ff @(posedge clk) begin
    if (start) begin
      divisor_q <= divisor;
      rem_acc   <= '0;
      quo_acc   <= div_zero ? '0 : dividend;
    end else if (running && !last) begin
      if (shifted >= {1'b0, divisor_q}) begin
        rem_acc <= DATA_WIDTH'(shifted - {1'b0, divisor_q});
        quo_acc <= {quo_acc[DATA_WIDTH-2:0], 1'b1};
      end else begin
        rem_acc <= shifted[DATA_WIDTH-1:0];
        quo_acc <= {quo_acc[DATA_WIDTH-2:0], 1'b0};
      end
    end
  end

  assign quotient  = quo_acc;
  assign remainder = rem_acc;

endmodule

`default_nettype wire

// ==== verilog/compute_stage.sv ====
/*
  Compute stage
  Runs one request at a time on the multiplier or the divider
  and holds the unsigned result until the result stage takes it.
*/

`timescale 1ns/1ps
`default_nettype none

module compute_stage
  import arith_pkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic req_valid,
  input  req_t req_data,
  output logic req_ready,
  output logic raw_valid,
  output raw_t raw_data,
  input  logic raw_ready
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BUSY,
    ST_FULL
  } state_t;

  state_t                state;
  logic                  accept;
  logic                  mul_start;
  logic                  div_start;
  logic                  mul_done;
  logic                  div_done;
  logic                  unit_done;
  logic [PROD_WIDTH-1:0] product;
  logic [DATA_WIDTH-1:0] quotient;
  logic [DATA_WIDTH-1:0] remainder;

  assign req_ready = (state == ST_IDLE);
  assign raw_valid = (state == ST_FULL);
  assign accept    = req_valid && req_ready;
  assign mul_start = accept && (req_data.op == OP_MUL);
  assign div_start = accept && (req_data.op == OP_DIV);
  assign unit_done = (raw_data.op == OP_MUL) ? mul_done : div_done;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: if (accept) state <= ST_BUSY;
        ST_BUSY: if (unit_done) state <= ST_FULL;
        ST_FULL: if (raw_ready) state <= ST_IDLE;
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Sign flags ride along while the unit works
  always_ff @(posedge clk) begin
    if (accept) begin
      raw_data.op        <= req_data.op;
      raw_data.left_neg  <= req_data.left_neg;
      raw_data.right_neg <= req_data.right_neg;
      raw_data.right_mag <= req_data.right_mag;
    end
    if (state == ST_BUSY && unit_done) begin
      raw_data.wide <= (raw_data.op == OP_MUL) ? product : {remainder, quotient};
    end
  end

  mult_unit mult (
    .clk      (clk),
    .reset    (reset),
    .start    (mul_start),
    .left_mag (req_data.left_mag),
    .right_mag(req_data.right_mag),
    .done     (mul_done),
    .product  (product)
  );

  div_unit div (
    .clk      (clk),
    .reset    (reset),
    .start    (div_start),
    .dividend (req_data.left_mag),
    .divisor  (req_data.right_mag),
    .done     (div_done),
    .quotient (quotient),
    .remainder(remainder)
  );

endmodule

`default_nettype wire

// ==== verilog/result_stage.sv ====
/*
  Result stage
  Restores signs on the unsigned compute result, scales the
  fixed-point product and registers the final outputs.
*/

`timescale 1ns/1ps
`default_nettype none

module result_stage
  import arith_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  raw_valid,
  input  raw_t                  raw_data,
  output logic                  raw_ready,
  output logic                  out_valid,
  output logic [DATA_WIDTH-1:0] out_result,
  output logic [DATA_WIDTH-1:0] out_remainder,
  input  logic                  out_ready
);

  logic                  neg;
  logic [PROD_WIDTH-1:0] signed_prod;
  logic [DATA_WIDTH-1:0] quo_mag;
  logic [DATA_WIDTH-1:0] rem_mag;
  logic [DATA_WIDTH-1:0] rem_adj;
  res_t                  res_next;
  res_t                  res_q;

  always_comb begin
    neg         = raw_data.left_neg ^ raw_data.right_neg;
    signed_prod = neg ? -raw_data.wide : raw_data.wide;
    quo_mag     = raw_data.wide[DATA_WIDTH-1:0];
    rem_mag     = raw_data.wide[PROD_WIDTH-1:DATA_WIDTH];
    // Remainder takes the sign of the divisor
    rem_adj     = (neg && rem_mag != '0) ? raw_data.right_mag - rem_mag : rem_mag;
    if (raw_data.op == OP_MUL) begin
      // Slice of the two's complement product floors toward minus infinity
      res_next.result    = signed_prod[FRAC_WIDTH+DATA_WIDTH-1:FRAC_WIDTH];
      res_next.remainder = '0;
    end else begin
      res_next.result    = neg ? -quo_mag : quo_mag;
      res_next.remainder = raw_data.right_neg ? -rem_adj : rem_adj;
    end
  end

  stage_reg #(
    .payload_t(res_t)
  ) res_reg (
    .clk      (clk),
    .reset    (reset),
    .in_valid (raw_valid),
    .in_data  (res_next),
    .in_ready (raw_ready),
    .out_valid(out_valid),
    .out_data (res_q),
    .out_ready(out_ready)
  );

  assign out_result    = res_q.result;
  assign out_remainder = res_q.remainder;

endmodule

`default_nettype wire

// ==== verilog/arith_unit.sv ====
/*
  Signed arithmetic unit
  Fixed-point multiply (16 fraction bits) and signed integer divide
  in a three-stage valid/ready pipeline. Results leave in order.
*/

`timescale 1ns/1ps
`default_nettype none

module arith_unit
  import arith_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  in_valid,
  input  op_t                   in_op,
  input  logic [DATA_WIDTH-1:0] in_left,
  input  logic [DATA_WIDTH-1:0] in_right,
  output logic                  in_ready,
  output logic                  out_valid,
  output logic [DATA_WIDTH-1:0] out_result,
  output logic [DATA_WIDTH-1:0] out_remainder,
  input  logic                  out_ready
);

  logic req_valid;
  logic req_ready;
  req_t req_data;
  logic raw_valid;
  logic raw_ready;
  raw_t raw_data;

  operand_stage operand (
    .clk      (clk),
    .reset    (reset),
    .in_valid (in_valid),
    .in_op    (in_op),
    .in_left  (in_left),
    .in_right (in_right),
    .in_ready (in_ready),
    .req_valid(req_valid),
    .req_data (req_data),
    .req_ready(req_ready)
  );

  compute_stage compute (
    .clk      (clk),
    .reset    (reset),
    .req_valid(req_valid),
    .req_data (req_data),
    .req_ready(req_ready),
    .raw_valid(raw_valid),
    .raw_data (raw_data),
    .raw_ready(raw_ready)
  );

  result_stage result (
    .clk          (clk),
    .reset        (reset),
    .raw_valid    (raw_valid),
    .raw_data     (raw_data),
    .raw_ready    (raw_ready),
    .out_valid    (out_valid),
    .out_result   (out_result),
    .out_remainder(out_remainder),
    .out_ready    (out_ready)
  );

endmodule

`default_nettype wire

// ==== test/arith_assertions.sv ====
/*
  Handshake and reset assertions for the arithmetic unit
  Output hold under back-pressure, input readiness when empty,
  and a cleared output after reset.
*/

`timescale 1ns/1ps
`default_nettype none

module arith_assertions
  import arith_pkg::*;
(
  input logic                  clk,
  input logic                  reset,
  input logic                  in_valid,
  input logic                  in_ready,
  input logic                  out_valid,
  input logic                  out_ready,
  input logic [DATA_WIDTH-1:0] out_result,
  input logic [DATA_WIDTH-1:0] out_remainder
);

  logic [2:0] in_flight;

  // Operations accepted at the input and not yet delivered
  always_ff @(posedge clk) begin
    if (reset) begin
      in_flight <= '0;
    end else begin
      in_flight <= in_flight + 3'(in_valid && in_ready) - 3'(out_valid && out_ready);
    end
  end

  output_held: assert property (@(posedge clk) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(out_result) && $stable(out_remainder))
    else $error("output changed while out_ready was low");

  ready_when_empty: assert property (@(posedge clk) disable iff (reset)
    in_flight == '0 |-> in_ready)
    else $error("in_ready low with an empty pipeline");

  reset_clears: assert property (@(posedge clk) reset |=> !out_valid)
    else $error("out_valid high after reset");

endmodule

bind arith_unit arith_assertions checks (
  .clk          (clk),
  .reset        (reset),
  .in_valid     (in_valid),
  .in_ready     (in_ready),
  .out_valid    (out_valid),
  .out_ready    (out_ready),
  .out_result   (out_result),
  .out_remainder(out_remainder)
);

`default_nettype wire

// ==== test/arith_tb.sv ====
/*
  Testbench for the signed arithmetic unit
  Random multiplies and divisions from a fixed seed, checked in order
  against a queue model, with directed corner cases and back-pressure.
*/

`timescale 1ns/1ps
`default_nettype none

module arith_tb
  import arith_pkg::*;
();

  localparam int N_MUL      = 150;
  localparam int N_DIV      = 150;
  localparam int N_DIRECTED = 8;
  localparam int N_MIXED    = 100;
  // Worst case per operation: divide latency plus input gaps and back-pressure
  localparam int OP_CYCLES  = 45;
  localparam int MAX_CYCLES = OP_CYCLES * (N_MUL + N_DIV + N_DIRECTED + N_MIXED) + 2000;

  logic                  clk = 1'b0;
  logic                  reset;
  logic                  in_valid;
  op_t                   in_op;
  logic [DATA_WIDTH-1:0] in_left;
  logic [DATA_WIDTH-1:0] in_right;
  logic                  in_ready;
  logic                  out_valid;
  logic [DATA_WIDTH-1:0] out_result;
  logic [DATA_WIDTH-1:0] out_remainder;
  logic                  out_ready;

  logic                  backpressure;
  logic [63:0]           expect_q[$];
  int                    cycles = 0;
  int                    errors = 0;
  int                    checks = 0;
  int                    error_base = 0;
  int                    tests_run = 0;
  int                    tests_failed = 0;

  arith_unit UUT (
    .clk          (clk),
    .reset        (reset),
    .in_valid     (in_valid),
    .in_op        (in_op),
    .in_left      (in_left),
    .in_right     (in_right),
    .in_ready     (in_ready),
    .out_valid    (out_valid),
    .out_result   (out_result),
    .out_remainder(out_remainder),
    .out_ready    (out_ready)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run stopped after %0d cycles, %0d results still missing",
               cycles, expect_q.size());
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, expected);
    end
  endtask

  // Signed rules: floor-scaled product, truncated quotient, remainder signed as divisor
  function automatic logic [63:0] expected_of(op_t op, logic [31:0] left,
                                              logic [31:0] right);
    logic signed [63:0] prod;
    longint             lv;
    longint             rv;
    longint             lmag;
    longint             rmag;
    longint             q;
    longint             t0;
    longint             t1;
    logic               differ;
    logic [31:0]        res;
    logic [31:0]        rem;
    lv = $signed(left);
    rv = $signed(right);
    differ = (lv < 0) != (rv < 0);
    if (op == OP_MUL) begin
      prod = lv * rv;
      res  = prod[FRAC_WIDTH+DATA_WIDTH-1:FRAC_WIDTH];
      rem  = '0;
    end else if (rv == 0) begin
      res = '0;
      rem = '0;
    end else begin
      lmag = (lv < 0) ? -lv : lv;
      rmag = (rv < 0) ? -rv : rv;
      q    = lmag / rmag;
      t0   = lmag % rmag;
      res  = differ ? 32'(-q) : 32'(q);
      t1   = (differ && t0 != 0) ? rmag - t0 : t0;
      rem  = (rv < 0) ? 32'(-t1) : 32'(t1);
    end
    return {res, rem};
  endfunction

  function automatic logic [31:0] random_operand();
    logic [31:0] mag;
    mag = $urandom >> $urandom_range(0, 24);
    return $urandom_range(0, 1) ? -mag : mag;
  endfunction

  // Called on a falling edge, returns on the falling edge after the transfer
  task automatic send_op(input op_t op, input logic [31:0] left, input logic [31:0] right);
    repeat ($urandom_range(0, 2)) @(negedge clk);
    in_valid = 1'b1;
    in_op    = op;
    in_left  = left;
    in_right = right;
    while (!in_ready) @(negedge clk);
    expect_q.push_back(expected_of(op, left, right));
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  task automatic wait_drain();
    while (expect_q.size() != 0) @(negedge clk);
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors != error_base) tests_failed++;
    $display("test %0d %s: done, %0d errors", tests_run, name, errors - error_base);
    error_base = errors;
  endtask

  // Output side: pick out_ready, then check a result that leaves at the next rising edge
  always @(negedge clk) begin
    logic [63:0] expected;
    if (!reset) begin
      out_ready = backpressure ? ($urandom_range(0, 3) != 0) : 1'b1;
      if (out_valid && out_ready) begin
        if (expect_q.size() == 0) begin
          errors++;
          $display("unexpected result at %0t ns with no operation outstanding", $time);
        end else begin
          expected = expect_q.pop_front();
          check_value("out_result", out_result, expected[63:32]);
          check_value("out_remainder", out_remainder, expected[31:0]);
        end
      end
    end
  end

  initial begin
    reset        = 1'b1;
    in_valid     = 1'b0;
    in_op        = OP_MUL;
    in_left      = '0;
    in_right     = '0;
    out_ready    = 1'b0;
    backpressure = 1'b0;
    void'($urandom(32'h49bd));
    repeat (5) @(negedge clk);
    reset = 1'b0;

    @(negedge clk);
    check_value("out_valid after reset", {31'b0, out_valid}, 32'd0);
    check_value("in_ready after reset", {31'b0, in_ready}, 32'd1);
    end_test("reset state");

    repeat (N_MUL) send_op(OP_MUL, random_operand(), random_operand());
    wait_drain();
    end_test("random multiply");

    repeat (N_DIV) send_op(OP_DIV, random_operand(), random_operand());
    wait_drain();
    end_test("random divide");

    send_op(OP_DIV, 32'd1234, 32'd0);
    send_op(OP_DIV, -32'sd5, 32'd0);
    send_op(OP_DIV, 32'h8000_0000, 32'hffff_ffff);
    send_op(OP_DIV, -32'sd12, 32'd4);
    send_op(OP_DIV, 32'd12, -32'sd4);
    send_op(OP_DIV, -32'sd12, -32'sd4);
    send_op(OP_DIV, -32'sd100000, 32'd250);
    send_op(OP_DIV, 32'h8000_0000, 32'd2);
    wait_drain();
    end_test("divide corner cases");

    backpressure = 1'b1;
    repeat (N_MIXED) begin
      send_op(op_t'($urandom_range(0, 1)), random_operand(), random_operand());
    end
    wait_drain();
    backpressure = 1'b0;
    // Nothing extra may follow the last expected result
    @(negedge clk);
    check_value("out_valid after drain", {31'b0, out_valid}, 32'd0);
    check_value("in_ready after drain", {31'b0, in_ready}, 32'd1);
    end_test("mixed stream with back-pressure");

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
verilog/arith_pkg.sv
verilog/stage_reg.sv
verilog/operand_stage.sv
verilog/mult_unit.sv
verilog/div_unit.sv
verilog/compute_stage.sv
verilog/result_stage.sv
verilog/arith_unit.sv
test/arith_assertions.sv
test/arith_tb.sv

// ==== Bender.yml ====
package:
  name: arith_unit

dependencies: {}

sources:
  # Design, in compile order
  - files:
      - verilog/arith_pkg.sv
      - verilog/stage_reg.sv
      - verilog/operand_stage.sv
      - verilog/mult_unit.sv
      - verilog/div_unit.sv
      - verilog/compute_stage.sv
      - verilog/result_stage.sv
      - verilog/arith_unit.sv

  # Testbench and bound assertions
  - target: test
    files:
      - test/arith_assertions.sv
      - test/arith_tb.sv
